// ==== src/tpu_load_pkg.sv ====
package tpu_load_pkg;

	// Memory beat and address widths.
	localparam int DATA_W = 64;
	localparam int ADDR_W = 32;
	localparam int NBURST_W = 25;

	// Geometry of a burst that is always read whole.
	localparam int BURST_BEATS = 16;
	localparam int BEAT_BYTES = 8;
	localparam int BURST_BYTES = BURST_BEATS * BEAT_BYTES;
	localparam int BURST_SHIFT = $clog2(BURST_BYTES);

	// Power-of-two chunk size in bursts.
	localparam int UNIT_BURSTS = 4;

	// Buffer destinations.
	localparam int N_CONV_UNIT = 8;
	localparam int CU_SEL_W = 3;

	typedef enum logic {
		REGION_WEIGHT,
		REGION_FEATURE
	} region_t;

	typedef struct packed {
		logic [ADDR_W-1:0]   base;
		logic [NBURST_W-1:0] n_bursts;
	} region_desc_t;

	// Weights first, then the feature map.
	typedef struct packed {
		region_desc_t wei;
		region_desc_t ftm;
	} layer_desc_t;

	typedef struct packed {
		logic                valid;
		region_t             region;
		logic [ADDR_W-1:0]   addr;
		logic [NBURST_W-1:0] n_bursts;
	} read_cmd_t;

	typedef struct packed {
		logic              valid;
		region_t           region;
		logic [DATA_W-1:0] data;
	} buf_beat_t;

	typedef struct packed {
		logic [N_CONV_UNIT-1:0] wb_we;
		logic [N_CONV_UNIT-1:0] fb_we;
		logic [DATA_W-1:0]      data;
	} buf_wr_t;

endpackage

// ==== src/region_walker.sv ====
`timescale 1ns/1ps

module region_walker (
	input  logic                                 aclk,
	input  logic                                 aresetn,
	input  logic                                 init_i,
	input  tpu_load_pkg::region_desc_t           desc_i,
	input  logic                                 advance_i,
	output logic [tpu_load_pkg::ADDR_W-1:0]      addr_o,
	output logic [tpu_load_pkg::NBURST_W-1:0]    n_bursts_o,
	output logic                                 done_o
);
	import tpu_load_pkg::*;

	logic [ADDR_W-1:0]   addr_r;
	logic [NBURST_W-1:0] chunk_r;
	logic [NBURST_W-1:0] rema_r;

	// Bursts still to be split into chunks.
	logic [NBURST_W-1:0] src_bursts;
	logic                src_big;

	assign src_bursts = init_i ? desc_i.n_bursts : rema_r;
	assign src_big    = (src_bursts > NBURST_W'(UNIT_BURSTS));

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			addr_r  <= '0;
			chunk_r <= '0;
			rema_r  <= '0;
		end else if (init_i || advance_i) begin
			// Take at most one unit of bursts per chunk.
			if (src_big) begin
				chunk_r <= NBURST_W'(UNIT_BURSTS);
				rema_r  <= src_bursts - NBURST_W'(UNIT_BURSTS);
			end else begin
				chunk_r <= src_bursts;
				rema_r  <= '0;
			end

			if (init_i) begin
				addr_r <= desc_i.base;
			end else begin
				// Skip past the chunk just read.
				addr_r <= addr_r + (ADDR_W'(chunk_r) << BURST_SHIFT);
			end
		end
	end

	assign addr_o     = addr_r;
	assign n_bursts_o = chunk_r;
	assign done_o     = (rema_r == '0);

endmodule

// ==== src/load_sequencer.sv ====
`timescale 1ns/1ps

module load_sequencer (
	input  logic                      aclk,
	input  logic                      aresetn,
	input  tpu_load_pkg::layer_desc_t desc_i,
	input  logic                      desc_valid_i,
	output logic                      desc_ready_o,
	input  logic                      rd_done_i,
	output tpu_load_pkg::read_cmd_t   cmd_o,
	output logic                      layer_start_o
);
	import tpu_load_pkg::*;

	typedef enum logic [2:0] {
		IDLE_ST,
		WEI_INIT_ST,
		WEI_LOAD_ST,
		WEI_NEXT_ST,
		FTM_INIT_ST,
		FTM_LOAD_ST,
		FTM_NEXT_ST
	} state_t;

	state_t      state;
	layer_desc_t desc_r;
	logic        issued_r;
	logic        load_st;

	logic [ADDR_W-1:0]   wei_addr;
	logic [NBURST_W-1:0] wei_n_bursts;
	logic                wei_done;
	logic [ADDR_W-1:0]   ftm_addr;
	logic [NBURST_W-1:0] ftm_n_bursts;
	logic                ftm_done;

	region_walker wei_walker_i (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.init_i     (state == WEI_INIT_ST),
		.desc_i     (desc_r.wei),
		.advance_i  (state == WEI_NEXT_ST),
		.addr_o     (wei_addr),
		.n_bursts_o (wei_n_bursts),
		.done_o     (wei_done)
	);

	region_walker ftm_walker_i (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.init_i     (state == FTM_INIT_ST),
		.desc_i     (desc_r.ftm),
		.advance_i  (state == FTM_NEXT_ST),
		.addr_o     (ftm_addr),
		.n_bursts_o (ftm_n_bursts),
		.done_o     (ftm_done)
	);

	assign desc_ready_o = (state == IDLE_ST);
	assign load_st      = (state == WEI_LOAD_ST) || (state == FTM_LOAD_ST);

	always_ff @(posedge aclk) begin
		if (desc_valid_i && desc_ready_o) begin
			desc_r <= desc_i;
		end
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state    <= IDLE_ST;
			issued_r <= 1'b0;
		end else begin
			// One command per visit to a load state.
			issued_r <= load_st;
			case (state)
				IDLE_ST:
					if (desc_valid_i) begin
						state <= WEI_INIT_ST;
					end
				WEI_INIT_ST: state <= WEI_LOAD_ST;
				WEI_LOAD_ST:
					if (rd_done_i) begin
						state <= wei_done ? FTM_INIT_ST : WEI_NEXT_ST;
					end
				WEI_NEXT_ST: state <= WEI_LOAD_ST;
				FTM_INIT_ST: state <= FTM_LOAD_ST;
				FTM_LOAD_ST:
					if (rd_done_i) begin
						state <= ftm_done ? IDLE_ST : FTM_NEXT_ST;
					end
				FTM_NEXT_ST: state <= FTM_LOAD_ST;
				default:     state <= IDLE_ST;
			endcase
		end
	end

	// Command comes straight from the walker of the current region.
	assign cmd_o.valid    = load_st && !issued_r;
	assign cmd_o.region   = (state == WEI_LOAD_ST) ? REGION_WEIGHT : REGION_FEATURE;
	assign cmd_o.addr     = (state == WEI_LOAD_ST) ? wei_addr : ftm_addr;
	assign cmd_o.n_bursts = (state == WEI_LOAD_ST) ? wei_n_bursts : ftm_n_bursts;

	// Pulses the cycle after a descriptor is taken.
	assign layer_start_o = (state == WEI_INIT_ST);

endmodule

// ==== src/burst_reader.sv ====
`timescale 1ns/1ps

module burst_reader (
	input  logic                              aclk,
	input  logic                              aresetn,
	input  tpu_load_pkg::read_cmd_t           cmd_i,
	output logic                              mem_req_o,
	output logic [tpu_load_pkg::ADDR_W-1:0]   mem_addr_o,
	input  logic                              mem_rvalid_i,
	input  logic [tpu_load_pkg::DATA_W-1:0]   mem_rdata_i,
	input  logic                              mem_rlast_i,
	output tpu_load_pkg::buf_beat_t           beat_o,
	output logic                              rd_done_o
);
	import tpu_load_pkg::*;

	logic                req_r;
	logic                done_r;
	logic [NBURST_W-1:0] rema_r;
	logic [ADDR_W-1:0]   addr_r;
	region_t             region_r;
	logic                burst_end;

	assign burst_end = mem_rvalid_i && mem_rlast_i;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			req_r  <= 1'b0;
			done_r <= 1'b0;
			rema_r <= '0;
		end else begin
			req_r  <= 1'b0;
			done_r <= 1'b0;
			if (cmd_i.valid) begin
				req_r  <= 1'b1;
				rema_r <= cmd_i.n_bursts;
			end else if (burst_end) begin
				// Either the chunk is over or the next burst goes out.
				if (rema_r == NBURST_W'(1)) begin
					done_r <= 1'b1;
				end else begin
					req_r <= 1'b1;
				end
				rema_r <= rema_r - NBURST_W'(1);
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (cmd_i.valid) begin
			addr_r   <= cmd_i.addr;
			region_r <= cmd_i.region;
		end else if (burst_end) begin
			addr_r <= addr_r + ADDR_W'(BURST_BYTES);
		end
	end

	assign mem_req_o  = req_r;
	assign mem_addr_o = addr_r;
	assign rd_done_o  = done_r;

	// Beats carry the region of the chunk in flight.
	assign beat_o.valid  = mem_rvalid_i;
	assign beat_o.region = region_r;
	assign beat_o.data   = mem_rdata_i;

endmodule

// ==== src/buffer_distributor.sv ====
`timescale 1ns/1ps

module buffer_distributor (
	input  logic                    aclk,
	input  logic                    aresetn,
	input  logic                    layer_start_i,
	input  tpu_load_pkg::buf_beat_t beat_i,
	output tpu_load_pkg::buf_wr_t   buf_wr_o
);
	import tpu_load_pkg::*;

	logic [CU_SEL_W-1:0]    wei_sel_r;
	logic [CU_SEL_W-1:0]    ftm_sel_r;
	logic [N_CONV_UNIT-1:0] wb_we_r;
	logic [N_CONV_UNIT-1:0] fb_we_r;
	logic [DATA_W-1:0]      data_r;

	// Round robin over the conv units.
	function automatic logic [CU_SEL_W-1:0] next_sel(input logic [CU_SEL_W-1:0] sel);
		if (sel == CU_SEL_W'(N_CONV_UNIT - 1)) begin
			return '0;
		end
		return sel + CU_SEL_W'(1);
	endfunction

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			wei_sel_r <= '0;
			ftm_sel_r <= '0;
			wb_we_r   <= '0;
			fb_we_r   <= '0;
		end else begin
			wb_we_r <= '0;
			fb_we_r <= '0;
			if (layer_start_i) begin
				wei_sel_r <= '0;
				ftm_sel_r <= '0;
			end else if (beat_i.valid) begin
				if (beat_i.region == REGION_WEIGHT) begin
					wb_we_r[wei_sel_r] <= 1'b1;
					wei_sel_r          <= next_sel(wei_sel_r);
				end else begin
					fb_we_r[ftm_sel_r] <= 1'b1;
					ftm_sel_r          <= next_sel(ftm_sel_r);
				end
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (beat_i.valid) begin
			data_r <= beat_i.data;
		end
	end

	assign buf_wr_o.wb_we = wb_we_r;
	assign buf_wr_o.fb_we = fb_we_r;
	assign buf_wr_o.data  = data_r;

endmodule

// ==== src/tpu_load_top.sv ====
`timescale 1ns/1ps

module tpu_load_top (
	input  logic                              aclk,
	input  logic                              aresetn,
	input  tpu_load_pkg::layer_desc_t         desc_i,
	input  logic                              desc_valid_i,
	output logic                              desc_ready_o,
	output logic                              mem_req_o,
	output logic [tpu_load_pkg::ADDR_W-1:0]   mem_addr_o,
	input  logic                              mem_rvalid_i,
	input  logic [tpu_load_pkg::DATA_W-1:0]   mem_rdata_i,
	input  logic                              mem_rlast_i,
	output tpu_load_pkg::buf_wr_t             buf_wr_o
);
	import tpu_load_pkg::*;

	read_cmd_t cmd;
	buf_beat_t beat;
	logic      rd_done;
	logic      layer_start;

	load_sequencer load_sequencer_i (
		.aclk          (aclk),
		.aresetn       (aresetn),
		.desc_i        (desc_i),
		.desc_valid_i  (desc_valid_i),
		.desc_ready_o  (desc_ready_o),
		.rd_done_i     (rd_done),
		.cmd_o         (cmd),
		.layer_start_o (layer_start)
	);

	burst_reader burst_reader_i (
		.aclk         (aclk),
		.aresetn      (aresetn),
		.cmd_i        (cmd),
		.mem_req_o    (mem_req_o),
		.mem_addr_o   (mem_addr_o),
		.mem_rvalid_i (mem_rvalid_i),
		.mem_rdata_i  (mem_rdata_i),
		.mem_rlast_i  (mem_rlast_i),
		.beat_o       (beat),
		.rd_done_o    (rd_done)
	);

	buffer_distributor buffer_distributor_i (
		.aclk          (aclk),
		.aresetn       (aresetn),
		.layer_start_i (layer_start),
		.beat_i        (beat),
		.buf_wr_o      (buf_wr_o)
	);

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic aclk_o,
	output logic aresetn_o
);

	// 8 ns period.
	initial begin
		aclk_o = 1'b0;
		forever #4 aclk_o = ~aclk_o;
	end

	// Reset low over two rising edges, released on a falling edge.
	initial begin
		aresetn_o = 1'b0;
		repeat (2) @(posedge aclk_o);
		@(negedge aclk_o);
		aresetn_o = 1'b1;
	end

endmodule

// ==== verif/tpu_load_chk.sv ====
`timescale 1ns/1ps

module tpu_load_chk (
	input logic                              aclk,
	input logic                              aresetn,
	input tpu_load_pkg::layer_desc_t         desc_i,
	input logic                              desc_valid_i,
	input logic                              desc_ready_i,
	input logic                              mem_req_i,
	input logic [tpu_load_pkg::ADDR_W-1:0]   mem_addr_i,
	input logic                              mem_rvalid_i,
	input logic [tpu_load_pkg::DATA_W-1:0]   mem_rdata_i,
	input logic                              mem_rlast_i,
	input tpu_load_pkg::buf_wr_t             buf_wr_i
);
	import tpu_load_pkg::*;

	logic                   accept;
	logic [ADDR_W-1:0]      exp_addr;
	logic [NBURST_W-1:0]    left;
	logic [ADDR_W-1:0]      ftm_base;
	logic [NBURST_W-1:0]    ftm_bursts;
	region_t                phase;
	region_t                burst_region;
	region_t                beat_region;
	logic                   in_flight;
	logic                   layer_act;
	logic [CU_SEL_W-1:0]    wsel;
	logic [CU_SEL_W-1:0]    fsel;
	logic                   exp_valid;
	logic [DATA_W-1:0]      exp_data;
	logic [N_CONV_UNIT-1:0] exp_wb;
	logic [N_CONV_UNIT-1:0] exp_fb;

	int n_reset   = 0;
	int n_addr    = 0;
	int n_flight  = 0;
	int n_onehot  = 0;
	int n_unit    = 0;
	int n_busy    = 0;
	int n_accept  = 0;
	int fail_cnt;

	assign accept   = desc_valid_i && desc_ready_i;
	assign fail_cnt = n_reset + n_addr + n_flight + n_onehot + n_unit + n_busy + n_accept;

	// The first beat may arrive on the edge of its own request.
	assign beat_region = mem_req_i ? phase : burst_region;

	// Reference walk of the request addresses of one layer.
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			exp_addr     <= '0;
			left         <= '0;
			ftm_base     <= '0;
			ftm_bursts   <= '0;
			phase        <= REGION_WEIGHT;
			burst_region <= REGION_WEIGHT;
			layer_act    <= 1'b0;
		end else if (accept) begin
			exp_addr   <= desc_i.wei.base;
			left       <= desc_i.wei.n_bursts;
			ftm_base   <= desc_i.ftm.base;
			ftm_bursts <= desc_i.ftm.n_bursts;
			phase      <= REGION_WEIGHT;
			layer_act  <= 1'b1;
		end else if (mem_req_i) begin
			burst_region <= phase;
			if (left == NBURST_W'(1) && phase == REGION_WEIGHT) begin
				exp_addr <= ftm_base;
				left     <= ftm_bursts;
				phase    <= REGION_FEATURE;
			end else begin
				exp_addr <= exp_addr + ADDR_W'(BURST_BYTES);
				left     <= left - NBURST_W'(1);
			end
		end else if (desc_ready_i) begin
			layer_act <= 1'b0;
		end
	end

	// Expected buffer writes trail the beats by one cycle.
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			in_flight <= 1'b0;
			wsel      <= '0;
			fsel      <= '0;
			exp_valid <= 1'b0;
			exp_wb    <= '0;
			exp_fb    <= '0;
			exp_data  <= '0;
		end else begin
			if (mem_req_i) begin
				in_flight <= 1'b1;
			end else if (mem_rvalid_i && mem_rlast_i) begin
				in_flight <= 1'b0;
			end
			exp_valid <= mem_rvalid_i;
			exp_data  <= mem_rdata_i;
			exp_wb    <= '0;
			exp_fb    <= '0;
			if (accept) begin
				wsel <= '0;
				fsel <= '0;
			end else if (mem_rvalid_i) begin
				if (beat_region == REGION_WEIGHT) begin
					exp_wb <= N_CONV_UNIT'(1) << wsel;
					wsel   <= (wsel == CU_SEL_W'(N_CONV_UNIT - 1)) ? '0 : wsel + CU_SEL_W'(1);
				end else begin
					exp_fb <= N_CONV_UNIT'(1) << fsel;
					fsel   <= (fsel == CU_SEL_W'(N_CONV_UNIT - 1)) ? '0 : fsel + CU_SEL_W'(1);
				end
			end
		end
	end

	a_reset_state: assert property (@(posedge aclk)
		!aresetn |=> (desc_ready_i && !mem_req_i && buf_wr_i.wb_we == '0 && buf_wr_i.fb_we == '0))
	else begin
		n_reset = n_reset + 1;
		$error("FAIL %0t: outputs not idle after reset", $time);
	end

	a_req_addr: assert property (@(posedge aclk) disable iff (!aresetn)
		mem_req_i |-> (left != '0 && mem_addr_i == exp_addr))
	else begin
		n_addr = n_addr + 1;
		$error("FAIL %0t: request addr %h, expected %h with %0d left", $time, mem_addr_i,
			exp_addr, left);
	end

	a_one_burst: assert property (@(posedge aclk) disable iff (!aresetn)
		mem_req_i |-> !in_flight)
	else begin
		n_flight = n_flight + 1;
		$error("FAIL %0t: request issued before the last beat", $time);
	end

	a_write_onehot: assert property (@(posedge aclk) disable iff (!aresetn)
		exp_valid |-> ($onehot({buf_wr_i.wb_we, buf_wr_i.fb_we}) && buf_wr_i.data == exp_data))
	else begin
		n_onehot = n_onehot + 1;
		$error("FAIL %0t: buffer write data %h, expected %h", $time, buf_wr_i.data, exp_data);
	end

	a_write_unit: assert property (@(posedge aclk) disable iff (!aresetn)
		buf_wr_i.wb_we == exp_wb && buf_wr_i.fb_we == exp_fb)
	else begin
		n_unit = n_unit + 1;
		$error("FAIL %0t: enables wb %b fb %b, expected wb %b fb %b", $time, buf_wr_i.wb_we,
			buf_wr_i.fb_we, exp_wb, exp_fb);
	end

	a_busy_low: assert property (@(posedge aclk) disable iff (!aresetn)
		(layer_act && (in_flight || left != '0 || phase == REGION_WEIGHT)) |-> !desc_ready_i)
	else begin
		n_busy = n_busy + 1;
		$error("FAIL %0t: desc_ready_o high while the layer is loading", $time);
	end

	a_accept_low: assert property (@(posedge aclk) disable iff (!aresetn)
		accept |=> !desc_ready_i)
	else begin
		n_accept = n_accept + 1;
		$error("FAIL %0t: desc_ready_o still high after acceptance", $time);
	end

endmodule

bind tpu_load_top tpu_load_chk tpu_load_chk_i (
	.aclk         (aclk),
	.aresetn      (aresetn),
	.desc_i       (desc_i),
	.desc_valid_i (desc_valid_i),
	.desc_ready_i (desc_ready_o),
	.mem_req_i    (mem_req_o),
	.mem_addr_i   (mem_addr_o),
	.mem_rvalid_i (mem_rvalid_i),
	.mem_rdata_i  (mem_rdata_i),
	.mem_rlast_i  (mem_rlast_i),
	.buf_wr_i     (buf_wr_o)
);

// ==== verif/tpu_load_tb.sv ====
`timescale 1ns/1ps

module tpu_load_tb;
	import tpu_load_pkg::*;

	logic              aclk;
	logic              aresetn;
	layer_desc_t       desc_i;
	logic              desc_valid_i;
	logic              desc_ready_o;
	logic              mem_req_o;
	logic [ADDR_W-1:0] mem_addr_o;
	logic              mem_rvalid_i;
	logic [DATA_W-1:0] mem_rdata_i;
	logic              mem_rlast_i;
	buf_wr_t           buf_wr_o;

	int   timeout_cnt = 0;
	logic run_ok;

	tb_clock_gen clock_gen_i (
		.aclk_o    (aclk),
		.aresetn_o (aresetn)
	);

	tpu_load_top tpu_load_top_i (
		.aclk         (aclk),
		.aresetn      (aresetn),
		.desc_i       (desc_i),
		.desc_valid_i (desc_valid_i),
		.desc_ready_o (desc_ready_o),
		.mem_req_o    (mem_req_o),
		.mem_addr_o   (mem_addr_o),
		.mem_rvalid_i (mem_rvalid_i),
		.mem_rdata_i  (mem_rdata_i),
		.mem_rlast_i  (mem_rlast_i),
		.buf_wr_o     (buf_wr_o)
	);

	// Beat data is the beat's own byte address.
	task automatic serve_burst(input logic [ADDR_W-1:0] addr);
		int gap;
		int i;
		gap = int'($urandom_range(3, 0));
		repeat (gap) @(negedge aclk);
		for (i = 0; i < BURST_BEATS; i++) begin
			if (i > 0) begin
				@(negedge aclk);
			end
			mem_rvalid_i = 1'b1;
			mem_rdata_i  = DATA_W'(addr) + DATA_W'(i * BEAT_BYTES);
			mem_rlast_i  = (i == BURST_BEATS - 1);
		end
	endtask

	initial begin : mem_model
		void'($urandom(32'h6f2a));
		mem_rvalid_i = 1'b0;
		mem_rlast_i  = 1'b0;
		mem_rdata_i  = '0;
		forever begin
			@(negedge aclk);
			mem_rvalid_i = 1'b0;
			mem_rlast_i  = 1'b0;
			if (mem_req_o === 1'b1) begin
				serve_burst(mem_addr_o);
			end
		end
	end

	task automatic wait_reset(output logic ok);
		int n;
		n = 0;
		while (aresetn !== 1'b1 && n < 20) begin
			@(posedge aclk);
			n++;
		end
		ok = (aresetn === 1'b1);
		if (!ok) begin
			timeout_cnt++;
			$display("Timeout at %0t: reset was never released", $time);
		end
		@(negedge aclk);
	endtask

	task automatic wait_ready(output logic ok);
		int n;
		n = 0;
		while (desc_ready_o !== 1'b1 && n < 4000) begin
			@(negedge aclk);
			n++;
		end
		ok = (desc_ready_o === 1'b1);
		if (!ok) begin
			timeout_cnt++;
			$display("Timeout at %0t: desc_ready_o did not rise within %0d cycles", $time, n);
		end
	endtask

	task automatic send_layer(
		input  logic [ADDR_W-1:0]   wei_base,
		input  logic [NBURST_W-1:0] wei_bursts,
		input  logic [ADDR_W-1:0]   ftm_base,
		input  logic [NBURST_W-1:0] ftm_bursts,
		output logic                ok
	);
		wait_ready(ok);
		if (ok) begin
			desc_i.wei.base     = wei_base;
			desc_i.wei.n_bursts = wei_bursts;
			desc_i.ftm.base     = ftm_base;
			desc_i.ftm.n_bursts = ftm_bursts;
			desc_valid_i        = 1'b1;
			@(negedge aclk);
			desc_valid_i = 1'b0;
		end
	endtask

	task automatic finish_run();
		int assert_cnt;
		assert_cnt = tpu_load_top_i.tpu_load_chk_i.fail_cnt;
		$display("Assertion failures: %0d, timeouts: %0d", assert_cnt, timeout_cnt);
		if (assert_cnt == 0 && timeout_cnt == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	initial begin : stimulus
		desc_i       = '0;
		desc_valid_i = 1'b0;
		run_ok       = 1'b1;
		wait_reset(run_ok);
		// Small regions inside one chunk.
		if (run_ok) begin
			send_layer(32'h0000_1000, NBURST_W'(2), 32'h0002_0000, NBURST_W'(3), run_ok);
		end
		// Several chunks per region, with a short last chunk.
		if (run_ok) begin
			send_layer(32'h0010_0000, NBURST_W'(9), 32'h0020_0080, NBURST_W'(6), run_ok);
		end
		if (run_ok) begin
			send_layer(32'h0030_0000, NBURST_W'(1), 32'h0040_0000, NBURST_W'(1), run_ok);
		end
		if (run_ok) begin
			wait_ready(run_ok);
		end
		if (run_ok) begin
			repeat (2) @(negedge aclk);
		end
		finish_run();
	end

endmodule

// ==== verilog.f ====
src/tpu_load_pkg.sv
src/region_walker.sv
src/load_sequencer.sv
src/burst_reader.sv
src/buffer_distributor.sv
src/tpu_load_top.sv
verif/tb_clock_gen.sv
verif/tpu_load_chk.sv
verif/tpu_load_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tpu_load_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
SIM_ARGS  := +verilator+error+limit+1000
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
